/* ps2_mouse_patterns.txt */
# op a b in hex. op 1 frame (a byte), 2 bad-parity frame (a byte), 3 read (a bytesel, b word)
# op 4 write (a bytesel, b word), 5 expect transmit (a byte), 6 interrupt total (a count)
3 1 0000
1 a5 0
1 3c 0
3 1 10a5
3 1 103c
3 1 0000
6 2 0
1 01 0
1 02 0
1 03 0
1 04 0
1 05 0
1 06 0
6 6 0
3 1 1001
3 1 1002
3 1 1003
3 1 1004
3 1 0000
2 5a 0
3 2 145a
3 1 105a
3 1 0000
6 7 0
4 1 00f4
3 1 0800
5 f4 0
3 1 0000
4 1 00e8
5 e8 0
3 1 0000
1 11 0
1 22 0
3 2 1011
4 2 8000
3 1 0000
1 33 0
3 1 1033
6 a 0

/* flist.f */
ps2_mouse_pkg.sv
ps2_host.sv
ps2_rx_fifo.sv
ps2_mouse_regs.sv
ps2_mouse_top.sv
tb_ps2_mouse_props.sv
tb_ps2_mouse.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the PS/2 mouse testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_ps2_mouse --Mdir obj_dir -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* tb_ps2_mouse.sv */
// Testbench for the PS/2 mouse controller with clock, reset, PS/2 device model,
// CPU bus tasks, pattern file runner, reference model and timeout
`timescale 1ns/1ps

module tb_ps2_mouse;

    localparam int tb_clkf = 10_000_000;
    localparam int tb_depth = 4;
    // 100 us inhibit at 10 MHz
    localparam int inhibit_cycles = tb_clkf / 10_000;
    localparam int tx_wait_limit = 2 * inhibit_cycles;

    logic clk;
    logic reset;
    logic cs;
    logic data_m_access;
    logic data_m_wr_en;
    ps2_mouse_pkg::cpu_bytesel_t data_m_bytesel;
    ps2_mouse_pkg::cpu_word_t    data_m_data_in;
    ps2_mouse_pkg::cpu_word_t    data_m_data_out;
    logic data_m_ack;
    logic ps2_intr;
    logic ps2_clk_in;
    logic ps2_dat_in;
    logic ps2_clk_out;
    logic ps2_dat_out;
    // Device side of the open-drain lines
    logic dev_clk;
    logic dev_dat;

    // Pattern lines and reference model
    logic [3:0]  pat_op [$];
    logic [15:0] pat_a [$];
    logic [15:0] pat_b [$];
    logic [7:0]  model_q [$];
    logic        model_err;
    logic        model_busy;
    logic [7:0]  model_tx;
    int model_intr = 0;
    int intr_seen = 0;
    int checks = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int idx;
    logic load_ok;

    // Wired-AND of host and device drivers
    assign ps2_clk_in = dev_clk & ps2_clk_out;
    assign ps2_dat_in = dev_dat & ps2_dat_out;

    ps2_mouse_top #(
        .clkf(tb_clkf),
        .fifo_depth(tb_depth)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .data_m_access(data_m_access),
        .data_m_wr_en(data_m_wr_en),
        .data_m_bytesel(data_m_bytesel),
        .data_m_data_in(data_m_data_in),
        .data_m_data_out(data_m_data_out),
        .data_m_ack(data_m_ack),
        .ps2_intr(ps2_intr),
        .ps2_clk_in(ps2_clk_in),
        .ps2_dat_in(ps2_dat_in),
        .ps2_clk_out(ps2_clk_out),
        .ps2_dat_out(ps2_dat_out)
    );

    always #50 clk = ~clk;

    // Interrupt pulses sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && ps2_intr)
            intr_seen++;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with the pattern run unfinished", cycle_limit);
            $display("Checks %0d, value errors %0d, other errors %0d",
                     checks, value_errors, other_errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    // Ends 10 ns after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_model(input string what, input logic [31:0] model,
                               input logic [31:0] file);
        assert (model === file) else begin
            $display("Pattern file expects %h for the %s but the model predicts %h",
                     file, what, model);
            other_errors++;
        end
    endtask

    // Cycles each opcode may take
    function automatic int pattern_cycles(input logic [3:0] op);
        case (op)
            4'h1, 4'h2: return 500;
            4'h5: return inhibit_cycles + 600;
            default: return 4;
        endcase
    endfunction

    task automatic load_patterns();
        int fd;
        int n;
        logic [3:0]  op_v;
        logic [15:0] a_v;
        logic [15:0] b_v;
        logic [8*128-1:0] line;
        load_ok = 1'b0;
        fd = $fopen("ps2_mouse_patterns.txt", "r");
        if (fd != 0) begin
            load_ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%h %h %h\n", op_v, a_v, b_v);
                if (n == 3) begin
                    pat_op.push_back(op_v);
                    pat_a.push_back(a_v);
                    pat_b.push_back(b_v);
                end else begin
                    // Comment line
                    n = $fgets(line, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // ======================================================================
    // CPU bus and PS/2 device model
    // ======================================================================

    task automatic cpu_access(input logic wr, input logic [1:0] bsel,
                              input logic [15:0] wdata, output logic [15:0] rdata);
        cs = 1'b1;
        data_m_access = 1'b1;
        data_m_wr_en = wr;
        data_m_bytesel = bsel;
        data_m_data_in = wdata;
        wait_cycles(1);
        cs = 1'b0;
        data_m_access = 1'b0;
        data_m_wr_en = 1'b0;
        data_m_bytesel = 2'b00;
        data_m_data_in = 16'h0000;
        rdata = data_m_data_out;
        check_value("data_m_ack", {31'b0, data_m_ack}, 32'h1);
        wait_cycles(1);
        check_value("data_m_ack", {31'b0, data_m_ack}, 32'h0);
    endtask

    // Device to host frame at 40 cycles per bit
    task automatic send_frame(input logic [7:0] data, input logic odd);
        logic [10:0] frame;
        int i;
        // Stop, parity, data LSB first, start
        frame = {1'b1, odd ? ~^data : ^data, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            dev_dat = frame[i];
            wait_cycles(10);
            dev_clk = 1'b0;
            wait_cycles(20);
            dev_clk = 1'b1;
            wait_cycles(10);
        end
        dev_dat = 1'b1;
        wait_cycles(20);
    endtask

    // Host to device transfer with inhibit, request, 10 bits in and the ack bit
    task automatic device_receive(output logic [9:0] bits, output logic ok);
        int waited;
        int i;
        bits = '0;
        waited = 0;
        while (ps2_clk_out !== 1'b0 && waited < tx_wait_limit) begin
            wait_cycles(1);
            waited++;
        end
        while (!(ps2_dat_out === 1'b0 && ps2_clk_out === 1'b1) && waited < tx_wait_limit) begin
            wait_cycles(1);
            waited++;
        end
        ok = (waited < tx_wait_limit);
        if (!ok) begin
            $display("Device model saw no request to send from the host");
            other_errors++;
        end else begin
            wait_cycles(10);
            for (i = 0; i < 10; i++) begin
                dev_clk = 1'b0;
                wait_cycles(20);
                // Device samples on its rising edge
                dev_clk = 1'b1;
                bits[i] = ps2_dat_in;
                wait_cycles(20);
            end
            dev_dat = 1'b0;
            wait_cycles(5);
            dev_clk = 1'b0;
            wait_cycles(20);
            dev_clk = 1'b1;
            wait_cycles(20);
            dev_dat = 1'b1;
            wait_cycles(5);
        end
    endtask

    // ======================================================================
    // Pattern execution against the reference model
    // ======================================================================

    task automatic execute_pattern(input logic [3:0] op, input logic [15:0] a,
                                   input logic [15:0] b);
        logic [15:0] word;
        logic [15:0] predicted;
        logic [7:0]  low;
        logic [9:0]  bits;
        logic        ok;
        case (op)
            4'h1, 4'h2: begin
                // Bad parity still stores the byte
                if (op == 4'h2)
                    model_err = 1'b1;
                if (model_q.size() < tb_depth) begin
                    model_q.push_back(a[7:0]);
                    model_intr++;
                end
                send_frame(a[7:0], op == 4'h1);
            end
            4'h3: begin
                low = (model_q.size() > 0) ? model_q[0] : 8'h00;
                predicted = {3'b000, model_q.size() > 0, model_busy, model_err, 2'b00, low};
                if (a[0] && model_q.size() > 0)
                    void'(model_q.pop_front());
                if (a[1])
                    model_err = 1'b0;
                cpu_access(1'b0, a[1:0], 16'h0000, word);
                check_value("data_m_data_out", {16'h0, word}, {16'h0, b});
                check_model("read word", {16'h0, predicted}, {16'h0, b});
            end
            4'h4: begin
                if (a[0] && !model_busy) begin
                    model_busy = 1'b1;
                    model_tx = b[7:0];
                end
                if (a[1] && b[ps2_mouse_pkg::flush_bit])
                    model_q.delete();
                cpu_access(1'b1, a[1:0], b, word);
                check_value("data_m_data_out", {16'h0, word}, 32'h0);
            end
            4'h5: begin
                device_receive(bits, ok);
                model_busy = 1'b0;
                check_model("transmit byte", {24'h0, model_tx}, {16'h0, a});
                if (ok) begin
                    check_value("ps2_dat_out data bits", {24'h0, bits[7:0]}, {16'h0, a});
                    check_value("ps2_dat_out parity", {31'b0, ^bits[8:0]}, 32'h1);
                    check_value("ps2_dat_out stop", {31'b0, bits[9]}, 32'h1);
                end
            end
            4'h6: begin
                check_value("ps2_intr pulses", intr_seen, {16'h0, a});
                check_model("interrupt count", model_intr, {16'h0, a});
            end
            default: begin
                $display("Unknown opcode %h in the pattern file", op);
                other_errors++;
            end
        endcase
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cs = 1'b0;
        data_m_access = 1'b0;
        data_m_wr_en = 1'b0;
        data_m_bytesel = 2'b00;
        data_m_data_in = 16'h0000;
        dev_clk = 1'b1;
        dev_dat = 1'b1;
        model_err = 1'b0;
        model_busy = 1'b0;
        model_tx = 8'h00;
        load_patterns();
        if (!load_ok) begin
            $display("Could not open the pattern file");
            other_errors++;
        end else begin
            // Limit from the summed pattern lengths plus reset and margin
            cycle_limit = 500;
            foreach (pat_op[i])
                cycle_limit += pattern_cycles(pat_op[i]);
            repeat (3) @(posedge clk);
            #10;
            reset = 1'b0;
            wait_cycles(5);
            for (idx = 0; idx < pat_op.size(); idx++)
                execute_pattern(pat_op[idx], pat_a[idx], pat_b[idx]);
        end
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tb_ps2_mouse_props.sv */
// Bound checks on the CPU acknowledge, the interrupt pulse
// and the PS/2 clock line of the mouse controller
`timescale 1ns/1ps

module tb_ps2_mouse_props (
    input logic clk,
    input logic reset,
    input logic cs,
    input logic data_m_access,
    input logic data_m_ack,
    input logic ps2_intr,
    input logic ps2_clk_out,
    input logic tx_busy
);

    // Ack one clock after an access with chip select
    ack_follows_access: assert property (
        @(posedge clk) disable iff (reset)
        (data_m_access && cs) |=> data_m_ack
    ) else $error("data_m_ack missing after an access with cs");

    // No ack without an access the cycle before
    ack_needs_access: assert property (
        @(posedge clk) disable iff (reset)
        !(data_m_access && cs) |=> !data_m_ack
    ) else $error("data_m_ack high without a preceding access");

    // One clock per stored byte
    intr_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        ps2_intr |=> !ps2_intr
    ) else $error("ps2_intr high for two clocks in a row");

    // Host only pulls the clock low while sending
    clk_released_idle: assert property (
        @(posedge clk) disable iff (reset)
        !tx_busy |-> ps2_clk_out
    ) else $error("ps2_clk_out pulled low while not transmitting");

endmodule

bind ps2_mouse_top tb_ps2_mouse_props props0 (
    .clk(clk),
    .reset(reset),
    .cs(cs),
    .data_m_access(data_m_access),
    .data_m_ack(data_m_ack),
    .ps2_intr(ps2_intr),
    .ps2_clk_out(ps2_clk_out),
    .tx_busy(tx_busy)
);

/* ps2_mouse_top.sv */
// PS/2 mouse controller top level: host, receive buffer and CPU registers
`timescale 1ns/1ps

module ps2_mouse_top #(
    parameter int clkf = 50_000_000,
    parameter int fifo_depth = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cs,
    input  logic                         data_m_access,
    input  logic                         data_m_wr_en,
    input  ps2_mouse_pkg::cpu_bytesel_t  data_m_bytesel,
    input  ps2_mouse_pkg::cpu_word_t     data_m_data_in,
    output ps2_mouse_pkg::cpu_word_t     data_m_data_out,
    output logic                         data_m_ack,
    output logic                         ps2_intr,
    input  logic                         ps2_clk_in,
    input  logic                         ps2_dat_in,
    output logic                         ps2_clk_out,
    output logic                         ps2_dat_out
);

    ps2_mouse_pkg::cpu_req_t  req;
    ps2_mouse_pkg::rx_frame_t rx_frame;
    ps2_mouse_pkg::ps2_byte_t rd_data;
    ps2_mouse_pkg::ps2_byte_t tx_data;
    logic rx_valid;
    logic tx_busy;
    logic start_tx;
    logic empty;
    logic full;
    logic fifo_wr_en;
    logic fifo_rd_en;
    logic fifo_flush;

    // CPU pins gathered into one request
    assign req.access = data_m_access;
    assign req.wr_en = data_m_wr_en;
    assign req.bytesel = data_m_bytesel;
    assign req.wdata = data_m_data_in;

    ps2_host #(
        .clkf(clkf)
    ) host0 (
        .clk(clk),
        .reset(reset),
        .ps2_clk_in(ps2_clk_in),
        .ps2_dat_in(ps2_dat_in),
        .ps2_clk_out(ps2_clk_out),
        .ps2_dat_out(ps2_dat_out),
        .start_tx(start_tx),
        .tx_data(tx_data),
        .rx_frame(rx_frame),
        .rx_valid(rx_valid),
        .tx_busy(tx_busy)
    );

    ps2_rx_fifo #(
        .fifo_depth(fifo_depth)
    ) fifo0 (
        .clk(clk),
        .reset(reset),
        .wr_en(fifo_wr_en),
        .wr_data(rx_frame.data),
        .rd_en(fifo_rd_en),
        .flush(fifo_flush),
        .rd_data(rd_data),
        .empty(empty),
        .full(full)
    );

    ps2_mouse_regs regs0 (
        .clk(clk),
        .reset(reset),
        .cs(cs),
        .req(req),
        .rx_frame(rx_frame),
        .rx_valid(rx_valid),
        .rd_data(rd_data),
        .empty(empty),
        .full(full),
        .tx_busy(tx_busy),
        .data_m_ack(data_m_ack),
        .data_m_data_out(data_m_data_out),
        .ps2_intr(ps2_intr),
        .fifo_wr_en(fifo_wr_en),
        .fifo_rd_en(fifo_rd_en),
        .fifo_flush(fifo_flush),
        .start_tx(start_tx),
        .tx_data(tx_data)
    );

endmodule

/* ps2_mouse_regs.sv */
// CPU register block: access decode, read word, ack, sticky error,
// transmit start, buffer control and interrupt pulse
`timescale 1ns/1ps

module ps2_mouse_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cs,
    input  ps2_mouse_pkg::cpu_req_t   req,
    input  ps2_mouse_pkg::rx_frame_t  rx_frame,
    input  logic                      rx_valid,
    input  ps2_mouse_pkg::ps2_byte_t  rd_data,
    input  logic                      empty,
    input  logic                      full,
    input  logic                      tx_busy,
    output logic                      data_m_ack,
    output ps2_mouse_pkg::cpu_word_t  data_m_data_out,
    output logic                      ps2_intr,
    output logic                      fifo_wr_en,
    output logic                      fifo_rd_en,
    output logic                      fifo_flush,
    output logic                      start_tx,
    output ps2_mouse_pkg::ps2_byte_t  tx_data
);

    logic do_read;
    logic do_write;
    logic unread_error;
    ps2_mouse_pkg::mouse_status_t status;
    ps2_mouse_pkg::ps2_byte_t     head;

    // ======================================================================
    // Access decode
    // ======================================================================

    assign do_read = req.access & cs & ~req.wr_en;
    assign do_write = req.access & cs & req.wr_en;

    // Pop only on a real read of the low lane
    assign fifo_rd_en = do_read & req.bytesel[ps2_mouse_pkg::lane_lo] & ~empty;
    assign fifo_flush = do_write & req.bytesel[ps2_mouse_pkg::lane_hi] &
                        req.wdata[ps2_mouse_pkg::flush_bit];

    // Low byte write sends a command to the mouse
    assign start_tx = do_write & req.bytesel[ps2_mouse_pkg::lane_lo];
    assign tx_data = req.wdata[7:0];

    // Full buffer drops the byte, and no interrupt for it
    assign fifo_wr_en = rx_valid & ~full;
    assign ps2_intr = fifo_wr_en;

    // ======================================================================
    // Read word
    // ======================================================================

    always_comb begin
        status = '0;
        status.rx_avail = ~empty;
        status.tx_busy = tx_busy;
        status.unread_error = unread_error;
    end

    // Empty buffer reads as zero
    assign head = empty ? 8'h00 : rd_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            data_m_ack <= 1'b0;
        else
            data_m_ack <= req.access & cs;
    end

    // Writes return zero
    always_ff @(posedge clk) begin
        data_m_data_out <= do_read ? {status, head} : '0;
    end

    // Sticky error, set wins over a clearing read
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            unread_error <= 1'b0;
        else if (rx_valid & rx_frame.error)
            unread_error <= 1'b1;
        else if (do_read & req.bytesel[ps2_mouse_pkg::lane_hi])
            unread_error <= 1'b0;
    end

endmodule

/* ps2_rx_fifo.sv */
// Circular byte buffer for received PS/2 data, with flush
`timescale 1ns/1ps

module ps2_rx_fifo #(
    parameter int fifo_depth = 32
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  ps2_mouse_pkg::ps2_byte_t wr_data,
    input  logic                     rd_en,
    input  logic                     flush,
    output ps2_mouse_pkg::ps2_byte_t rd_data,
    output logic                     empty,
    output logic                     full
);

    localparam int addr_w = $clog2(fifo_depth);

    ps2_mouse_pkg::ps2_byte_t mem [fifo_depth];

    // Extra top bit tells a wrapped full buffer from an empty one
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr[addr_w-1:0]] <= wr_data;
    end

    // Head of the buffer, visible without a read cycle
    assign rd_data = mem[rd_ptr[addr_w-1:0]];

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                  (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

endmodule

/* ps2_host.sv */
// PS/2 host: line synchronizers, frame receiver with odd parity check
// and the host-to-device request and transmit sequencer
`timescale 1ns/1ps

module ps2_host #(
    parameter int clkf = 50_000_000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ps2_clk_in,
    input  logic                      ps2_dat_in,
    output logic                      ps2_clk_out,
    output logic                      ps2_dat_out,
    input  logic                      start_tx,
    input  ps2_mouse_pkg::ps2_byte_t  tx_data,
    output ps2_mouse_pkg::rx_frame_t  rx_frame,
    output logic                      rx_valid,
    output logic                      tx_busy
);

    // 100 us clock inhibit before a request to send
    localparam int inhibit_cycles = clkf / 10_000;
    // About 2 ms without a device clock edge abandons a partial frame
    localparam int wd_cycles = clkf / 500;
    localparam int timer_w = $clog2(wd_cycles + 1);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic       clk_rise;
    logic       dat_s;

    ps2_mouse_pkg::host_state_t state;
    logic [3:0]         bit_cnt;
    logic [timer_w-1:0] timer;
    logic               wd_expired;
    logic               inhibit_done;

    logic [9:0] rx_shift;
    logic [9:0] rx_next;
    logic       rx_done;
    logic       start_err;
    logic [9:0] tx_shift;

    // ======================================================================
    // Line synchronizers and edge detect
    // ======================================================================

    // Idle lines are high, so the flops reset to 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk_in};
            dat_sync <= {dat_sync[0], ps2_dat_in};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];
    assign clk_rise = ~clk_prev & clk_sync[1];
    assign dat_s = dat_sync[1];

    assign wd_expired = (timer == timer_w'(wd_cycles - 1));
    assign inhibit_done = (timer == timer_w'(inhibit_cycles - 1));

    // Bits arrive LSB first: data[7:0], parity, stop
    assign rx_next = {dat_s, rx_shift[9:1]};
    assign rx_done = (state == ps2_mouse_pkg::rx_bits) && clk_fall && (bit_cnt == 4'd9);

    // ======================================================================
    // Sequencer
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ps2_mouse_pkg::idle;
            bit_cnt <= '0;
            timer <= '0;
            rx_valid <= 1'b0;
            tx_busy <= 1'b0;
            ps2_clk_out <= 1'b1;
            ps2_dat_out <= 1'b1;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                ps2_mouse_pkg::idle: begin
                    timer <= '0;
                    bit_cnt <= '0;
                    // Transmit request has priority over a new start bit
                    if (start_tx) begin
                        tx_busy <= 1'b1;
                        ps2_clk_out <= 1'b0;
                        state <= ps2_mouse_pkg::tx_inhibit;
                    end else if (clk_fall) begin
                        state <= ps2_mouse_pkg::rx_bits;
                    end
                end
                ps2_mouse_pkg::rx_bits: begin
                    timer <= clk_fall ? '0 : timer + 1'b1;
                    if (clk_fall) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // Stop bit sampled, frame complete
                        if (bit_cnt == 4'd9) begin
                            rx_valid <= 1'b1;
                            state <= ps2_mouse_pkg::idle;
                        end
                    end else if (wd_expired) begin
                        state <= ps2_mouse_pkg::idle;
                    end
                end
                ps2_mouse_pkg::tx_inhibit: begin
                    // Clock held low, then pull data low as start bit
                    timer <= timer + 1'b1;
                    if (inhibit_done) begin
                        ps2_dat_out <= 1'b0;
                        state <= ps2_mouse_pkg::tx_request;
                    end
                end
                ps2_mouse_pkg::tx_request: begin
                    // Release clock, device now drives it
                    ps2_clk_out <= 1'b1;
                    state <= ps2_mouse_pkg::tx_bits;
                end
                ps2_mouse_pkg::tx_bits: begin
                    // New bit on each falling edge, device samples on rising
                    if (clk_fall) begin
                        ps2_dat_out <= tx_shift[0];
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd9)
                            state <= ps2_mouse_pkg::tx_ack;
                    end
                end
                ps2_mouse_pkg::tx_ack: begin
                    // Device pulls data low for one bit, done on its rising edge
                    if (clk_fall && !dat_s)
                        bit_cnt <= 4'd11;
                    if (clk_rise && bit_cnt == 4'd11) begin
                        tx_busy <= 1'b0;
                        ps2_dat_out <= 1'b1;
                        state <= ps2_mouse_pkg::idle;
                    end
                end
                default: state <= ps2_mouse_pkg::idle;
            endcase
        end
    end

    // ======================================================================
    // Shift registers and received frame
    // ======================================================================

    always_ff @(posedge clk) begin
        // Stop 1, odd parity, then data LSB first
        if (state == ps2_mouse_pkg::idle && start_tx)
            tx_shift <= {1'b1, ~^tx_data, tx_data};
        else if (state == ps2_mouse_pkg::tx_bits && clk_fall)
            tx_shift <= {1'b1, tx_shift[9:1]};
        // A start bit of 1 is kept as a framing error
        if (state == ps2_mouse_pkg::idle && clk_fall)
            start_err <= dat_s;
        if (state == ps2_mouse_pkg::rx_bits && clk_fall)
            rx_shift <= rx_next;
        if (rx_done) begin
            rx_frame.data <= rx_next[7:0];
            rx_frame.error <= start_err | ~(^rx_next[8:0]) | ~rx_next[9];
        end
    end

endmodule

/* ps2_mouse_pkg.sv */
// Shared types for the PS/2 mouse controller: data widths, CPU request,
// receive frame, status byte, host sequencer states and register bits
package ps2_mouse_pkg;

    // ======================================================================
    // Data widths
    // ======================================================================

    // One byte on the PS/2 wire
    typedef logic [7:0] ps2_byte_t;

    // CPU data port word and its byte lane enables
    typedef logic [15:0] cpu_word_t;
    typedef logic [1:0] cpu_bytesel_t;

    // ======================================================================
    // Register layout
    // ======================================================================

    // Byte lanes of the data port
    localparam int lane_lo = 0;
    localparam int lane_hi = 1;

    // Write data bit that empties the receive buffer
    localparam int flush_bit = 15;

    // Received byte plus parity / start / stop error
    typedef struct packed {
        ps2_byte_t data;
        logic      error;
    } rx_frame_t;

    // CPU access as seen by the register block
    typedef struct packed {
        logic         access;
        logic         wr_en;
        cpu_bytesel_t bytesel;
        cpu_word_t    wdata;
    } cpu_req_t;

    // High byte of every read word
    typedef struct packed {
        logic [2:0] zero_hi;
        logic       rx_avail;
        logic       tx_busy;
        logic       unread_error;
        logic [1:0] zero_lo;
    } mouse_status_t;

    // Host line sequencer
    typedef enum logic [2:0] {
        idle,
        rx_bits,
        tx_inhibit,
        tx_request,
        tx_bits,
        tx_ack
    } host_state_t;

endpackage
